//--- hdl/ldq_conf_pkg.sv
package ldq_conf_pkg;

  // load queue
  localparam int LDQ_SIZE  = 4;
  localparam int LDQ_IDX_W = 2;  // log2 of LDQ_SIZE

  // miss queue slots, one-hot addressed
  localparam int LRQ_SIZE  = 8;

  // commit id from the ROB
  localparam int CMT_ID_W  = 6;

  localparam int VADDR_W   = 32;

endpackage

//--- hdl/ldq_types_pkg.sv
package ldq_types_pkg;

  import ldq_conf_pkg::*;

  typedef logic [LDQ_IDX_W-1:0] ldq_idx_t;
  typedef logic [LDQ_SIZE-1:0]  ldq_oh_t;   // one bit per entry
  typedef logic [LRQ_SIZE-1:0]  lrq_oh_t;   // one bit per miss queue slot
  typedef logic [CMT_ID_W-1:0]  cmt_id_t;
  typedef logic [VADDR_W-1:0]   vaddr_t;

  // life of one load in the queue
  typedef enum logic [2:0] {
    FREE     = 3'd0,
    INIT     = 3'd1,  // allocated, waiting for EX1
    TLB_HAZ  = 3'd2,
    EX2_RUN  = 3'd3,
    LRQ_HAZ  = 3'd4,
    READY    = 3'd5,  // waiting for a rerun slot
    EX3_DONE = 3'd6
  } ldq_state_e;

  // EX2 outcome reported by the cache / miss queue
  typedef enum logic [2:0] {
    NONE         = 3'd0,
    L1D_CONFLICT = 3'd1,
    LRQ_ASSIGNED = 3'd2,
    LRQ_CONFLICT = 3'd3,
    LRQ_FULL     = 3'd4
  } ex2_haz_e;

endpackage

//--- hdl/ldq_entry.sv
`timescale 1ns/1ns

module ldq_entry #(
  parameter int ENTRY_IDX = 0
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  logic                     i_alloc,
  input  ldq_types_pkg::cmt_id_t   i_disp_cmt_id,

  input  logic                     i_ex1_valid,
  input  ldq_types_pkg::ldq_idx_t  i_ex1_index,
  input  logic                     i_ex1_tlb_haz,
  input  ldq_types_pkg::vaddr_t    i_ex1_vaddr,

  input  logic                     i_ex2_valid,
  input  ldq_types_pkg::ldq_idx_t  i_ex2_index,
  input  ldq_types_pkg::ex2_haz_e  i_ex2_haz_typ,
  input  ldq_types_pkg::lrq_oh_t   i_ex2_lrq_oh,

  input  logic                     i_tlb_resolve,
  input  logic                     i_lrq_resolve_valid,
  input  ldq_types_pkg::lrq_oh_t   i_lrq_resolve_oh,

  input  logic                     i_rerun_accept,
  input  logic                     i_retire,

  output ldq_types_pkg::ldq_state_e o_state,
  output ldq_types_pkg::cmt_id_t   o_cmt_id,
  output ldq_types_pkg::vaddr_t    o_vaddr
);

  import ldq_conf_pkg::*;
  import ldq_types_pkg::*;

  localparam ldq_idx_t MY_IDX = LDQ_IDX_W'(ENTRY_IDX);

  ldq_state_e r_state;
  cmt_id_t    r_cmt_id;
  vaddr_t     r_vaddr;
  lrq_oh_t    r_lrq_oh;  // slot we are waiting on

  logic       w_ex1_hit;
  logic       w_ex2_hit;
  logic       w_lrq_same_cycle;
  ldq_state_e w_ex2_next;

  assign w_ex1_hit = i_ex1_valid && (i_ex1_index == MY_IDX);
  assign w_ex2_hit = i_ex2_valid && (i_ex2_index == MY_IDX);

  // miss queue entry freed in the very cycle we saw the conflict
  assign w_lrq_same_cycle = (i_ex2_haz_typ == LRQ_CONFLICT) &&
                            i_lrq_resolve_valid &&
                            (i_lrq_resolve_oh == i_ex2_lrq_oh);

  always_comb begin
    case (i_ex2_haz_typ)
      L1D_CONFLICT: w_ex2_next = READY;
      LRQ_ASSIGNED: w_ex2_next = READY;  // rerun to pick up the fill
      LRQ_CONFLICT: w_ex2_next = w_lrq_same_cycle ? READY : LRQ_HAZ;
      LRQ_FULL:     w_ex2_next = LRQ_HAZ;
      default:      w_ex2_next = EX3_DONE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= FREE;
    end else begin
      case (r_state)
        FREE: begin
          if (i_alloc) begin
            r_state <= INIT;
          end
        end
        INIT: begin
          if (w_ex1_hit) begin
            r_state <= i_ex1_tlb_haz ? TLB_HAZ : EX2_RUN;
          end
        end
        TLB_HAZ: begin
          if (i_tlb_resolve) begin
            r_state <= READY;
          end
        end
        EX2_RUN: begin
          if (w_ex2_hit) begin
            r_state <= w_ex2_next;
          end
        end
        LRQ_HAZ: begin
          if (i_lrq_resolve_valid && (i_lrq_resolve_oh == r_lrq_oh)) begin
            r_state <= READY;
          end
        end
        READY: begin
          if (i_rerun_accept) begin
            r_state <= INIT;  // goes back through EX1
          end
        end
        EX3_DONE: begin
          if (i_retire) begin
            r_state <= FREE;
          end
        end
        default: r_state <= FREE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if ((r_state == FREE) && i_alloc) begin
      r_cmt_id <= i_disp_cmt_id;
    end
    if ((r_state == INIT) && w_ex1_hit) begin
      r_vaddr <= i_ex1_vaddr;  // kept on a TLB miss too
    end
    if ((r_state == EX2_RUN) && w_ex2_hit) begin
      r_lrq_oh <= i_ex2_lrq_oh;
    end
  end

  assign o_state  = r_state;
  assign o_cmt_id = r_cmt_id;
  assign o_vaddr  = r_vaddr;

endmodule

//--- hdl/ldq_rerun_pick.sv
`timescale 1ns/1ns

module ldq_rerun_pick (
  input  logic                      i_clk,
  input  logic                      i_reset_n,

  input  ldq_types_pkg::ldq_state_e i_states [ldq_conf_pkg::LDQ_SIZE],
  input  ldq_types_pkg::vaddr_t     i_vaddrs [ldq_conf_pkg::LDQ_SIZE],
  input  ldq_types_pkg::ldq_idx_t   i_head,
  input  logic                      i_rerun_ready,

  output logic                      o_rerun_valid,
  output ldq_types_pkg::ldq_idx_t   o_rerun_index,
  output ldq_types_pkg::vaddr_t     o_rerun_vaddr,
  output ldq_types_pkg::ldq_oh_t    o_rerun_accept_oh
);

  import ldq_conf_pkg::*;
  import ldq_types_pkg::*;

  logic     w_any_ready;
  ldq_idx_t w_pick_idx;
  logic     r_hold;       // offer stalled last cycle
  ldq_idx_t r_hold_idx;

  // oldest first, scanning backwards so the nearest to head wins
  always_comb begin
    ldq_idx_t idx;
    w_any_ready = 1'b0;
    w_pick_idx  = i_head;
    for (int i = LDQ_SIZE - 1; i >= 0; i--) begin
      idx = i_head + ldq_idx_t'(i);
      if (i_states[idx] == READY) begin
        w_any_ready = 1'b1;
        w_pick_idx  = idx;
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_hold <= 1'b0;
    end else begin
      r_hold <= o_rerun_valid && !i_rerun_ready;
    end
  end

  always_ff @(posedge i_clk) begin
    r_hold_idx <= o_rerun_index;
  end

  // a held entry stays READY until accepted, so valid needs no hold term
  assign o_rerun_valid     = w_any_ready;
  assign o_rerun_index     = r_hold ? r_hold_idx : w_pick_idx;
  assign o_rerun_vaddr     = i_vaddrs[o_rerun_index];
  assign o_rerun_accept_oh = (o_rerun_valid && i_rerun_ready) ?
                             (ldq_oh_t'(1) << o_rerun_index) : '0;

endmodule

//--- hdl/ldq_retire_ctl.sv
`timescale 1ns/1ns

module ldq_retire_ctl (
  input  logic                      i_clk,
  input  logic                      i_reset_n,

  input  logic                      i_disp_valid,
  input  ldq_types_pkg::ldq_state_e i_states  [ldq_conf_pkg::LDQ_SIZE],
  input  ldq_types_pkg::cmt_id_t    i_cmt_ids [ldq_conf_pkg::LDQ_SIZE],
  input  logic                      i_done_ready,

  output logic                      o_disp_ready,
  output ldq_types_pkg::ldq_idx_t   o_disp_index,
  output ldq_types_pkg::ldq_oh_t    o_alloc_oh,
  output ldq_types_pkg::ldq_idx_t   o_head,

  output logic                      o_done_valid,
  output ldq_types_pkg::ldq_idx_t   o_done_index,
  output ldq_types_pkg::cmt_id_t    o_done_cmt_id,
  output ldq_types_pkg::ldq_oh_t    o_retire_oh
);

  import ldq_conf_pkg::*;
  import ldq_types_pkg::*;

  localparam logic [LDQ_IDX_W:0] FULL_CNT = (LDQ_IDX_W + 1)'(LDQ_SIZE);

  ldq_idx_t             r_head;
  ldq_idx_t             r_tail;
  logic [LDQ_IDX_W:0]   r_count;  // entries in use

  logic                 w_disp_fire;
  logic                 w_retire;

  assign o_disp_ready = (r_count != FULL_CNT);
  assign w_disp_fire  = i_disp_valid && o_disp_ready;

  // only the head may leave, which keeps retire in program order
  assign o_done_valid = (i_states[r_head] == EX3_DONE);
  assign w_retire     = o_done_valid && i_done_ready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= '0;
    end else begin
      if (w_disp_fire) begin
        r_tail <= r_tail + ldq_idx_t'(1);
      end
      if (w_retire) begin
        r_head <= r_head + ldq_idx_t'(1);
      end
      case ({w_disp_fire, w_retire})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;  // none or both
      endcase
    end
  end

  assign o_disp_index  = r_tail;
  assign o_alloc_oh    = w_disp_fire ? (ldq_oh_t'(1) << r_tail) : '0;
  assign o_head        = r_head;

  assign o_done_index  = r_head;
  assign o_done_cmt_id = i_cmt_ids[r_head];
  assign o_retire_oh   = w_retire ? (ldq_oh_t'(1) << r_head) : '0;

endmodule

//--- hdl/ldq_top.sv
`timescale 1ns/1ns

module ldq_top (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  // dispatch
  input  logic                     i_disp_valid,
  input  ldq_types_pkg::cmt_id_t   i_disp_cmt_id,
  output logic                     o_disp_ready,
  output ldq_types_pkg::ldq_idx_t  o_disp_index,

  // EX1 update
  input  logic                     i_ex1_valid,
  input  ldq_types_pkg::ldq_idx_t  i_ex1_index,
  input  logic                     i_ex1_tlb_haz,
  input  ldq_types_pkg::vaddr_t    i_ex1_vaddr,

  // EX2 update
  input  logic                     i_ex2_valid,
  input  ldq_types_pkg::ldq_idx_t  i_ex2_index,
  input  ldq_types_pkg::ex2_haz_e  i_ex2_haz_typ,
  input  ldq_types_pkg::lrq_oh_t   i_ex2_lrq_oh,

  // hazard release
  input  logic                     i_tlb_resolve,
  input  logic                     i_lrq_resolve_valid,
  input  ldq_types_pkg::lrq_oh_t   i_lrq_resolve_oh,

  // rerun request
  output logic                     o_rerun_valid,
  output ldq_types_pkg::ldq_idx_t  o_rerun_index,
  output ldq_types_pkg::vaddr_t    o_rerun_vaddr,
  input  logic                     i_rerun_ready,

  // retire
  output logic                     o_done_valid,
  output ldq_types_pkg::ldq_idx_t  o_done_index,
  output ldq_types_pkg::cmt_id_t   o_done_cmt_id,
  input  logic                     i_done_ready
);

  import ldq_conf_pkg::*;
  import ldq_types_pkg::*;

  ldq_state_e w_states  [LDQ_SIZE];
  cmt_id_t    w_cmt_ids [LDQ_SIZE];
  vaddr_t     w_vaddrs  [LDQ_SIZE];

  ldq_oh_t    w_alloc_oh;
  ldq_oh_t    w_retire_oh;
  ldq_oh_t    w_accept_oh;
  ldq_idx_t   w_head;

  for (genvar g = 0; g < LDQ_SIZE; g++) begin : g_entry
    ldq_entry #(
      .ENTRY_IDX (g)
    ) ldq_entry_i (
      .i_clk               (i_clk),
      .i_reset_n           (i_reset_n),
      .i_alloc             (w_alloc_oh[g]),
      .i_disp_cmt_id       (i_disp_cmt_id),
      .i_ex1_valid         (i_ex1_valid),
      .i_ex1_index         (i_ex1_index),
      .i_ex1_tlb_haz       (i_ex1_tlb_haz),
      .i_ex1_vaddr         (i_ex1_vaddr),
      .i_ex2_valid         (i_ex2_valid),
      .i_ex2_index         (i_ex2_index),
      .i_ex2_haz_typ       (i_ex2_haz_typ),
      .i_ex2_lrq_oh        (i_ex2_lrq_oh),
      .i_tlb_resolve       (i_tlb_resolve),
      .i_lrq_resolve_valid (i_lrq_resolve_valid),
      .i_lrq_resolve_oh    (i_lrq_resolve_oh),
      .i_rerun_accept      (w_accept_oh[g]),
      .i_retire            (w_retire_oh[g]),
      .o_state             (w_states[g]),
      .o_cmt_id            (w_cmt_ids[g]),
      .o_vaddr             (w_vaddrs[g])
    );
  end

  ldq_rerun_pick ldq_rerun_pick_i (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_states          (w_states),
    .i_vaddrs          (w_vaddrs),
    .i_head            (w_head),  // age reference
    .i_rerun_ready     (i_rerun_ready),
    .o_rerun_valid     (o_rerun_valid),
    .o_rerun_index     (o_rerun_index),
    .o_rerun_vaddr     (o_rerun_vaddr),
    .o_rerun_accept_oh (w_accept_oh)
  );

  ldq_retire_ctl ldq_retire_ctl_i (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp_valid  (i_disp_valid),
    .i_states      (w_states),
    .i_cmt_ids     (w_cmt_ids),
    .i_done_ready  (i_done_ready),
    .o_disp_ready  (o_disp_ready),
    .o_disp_index  (o_disp_index),
    .o_alloc_oh    (w_alloc_oh),
    .o_head        (w_head),
    .o_done_valid  (o_done_valid),
    .o_done_index  (o_done_index),
    .o_done_cmt_id (o_done_cmt_id),
    .o_retire_oh   (w_retire_oh)
  );

endmodule

//--- tests/ldq_tb_tasks.svh
task automatic dispatch_load(output ldq_idx_t idx);
  cmt_id_t id;
  int      n;
  id = cmt_id_t'(next_bits(CMT_ID_W));
  @(posedge clk);
  disp_valid  <= 1'b1;
  disp_cmt_id <= id;
  n = 0;
  @(negedge clk);
  while (!disp_ready) begin
    n++;
    if (n > TIMEOUT) stop_run("Timeout: dispatch was never accepted");
    @(negedge clk);
  end
  check_eq(32'(disp_index), 32'(model_tail), "dispatch index");
  idx        = model_tail;
  model_tail = model_tail + ldq_idx_t'(1);
  exp_ids.push_back(id);
  @(posedge clk);  // transfer happens here
  disp_valid <= 1'b0;
endtask

task automatic ex1_update(input ldq_idx_t idx, input logic haz, input vaddr_t va);
  @(posedge clk);
  ex1_valid   <= 1'b1;
  ex1_index   <= idx;
  ex1_tlb_haz <= haz;
  ex1_vaddr   <= va;
  @(posedge clk);
  ex1_valid   <= 1'b0;
  ex1_tlb_haz <= 1'b0;
endtask

task automatic ex2_update(input ldq_idx_t idx, input ex2_haz_e typ, input lrq_oh_t slot,
                          input logic same_rel);
  @(posedge clk);
  ex2_valid         <= 1'b1;
  ex2_index         <= idx;
  ex2_haz_typ       <= typ;
  ex2_lrq_oh        <= slot;
  lrq_resolve_valid <= same_rel;  // miss queue frees the slot this cycle
  lrq_resolve_oh    <= slot;
  @(posedge clk);
  ex2_valid         <= 1'b0;
  lrq_resolve_valid <= 1'b0;
endtask

task automatic tlb_pulse();
  @(posedge clk);
  tlb_resolve <= 1'b1;
  @(posedge clk);
  tlb_resolve <= 1'b0;
endtask

task automatic lrq_pulse(input lrq_oh_t slot);
  @(posedge clk);
  lrq_resolve_valid <= 1'b1;
  lrq_resolve_oh    <= slot;
  @(posedge clk);
  lrq_resolve_valid <= 1'b0;
endtask

// clean pass through EX1 and EX2
task automatic finish_load(input ldq_idx_t idx);
  vaddr_t va;
  va = next_bits(VADDR_W);
  ex1_update(idx, 1'b0, va);
  ex2_update(idx, NONE, '0, 1'b0);
endtask

task automatic take_rerun(input ldq_idx_t idx, input vaddr_t va);
  wait_rerun();
  check_eq(32'(rerun_index), 32'(idx), "rerun index");
  check_eq(rerun_vaddr, va, "rerun vaddr");
  @(posedge clk);
  rerun_ready <= 1'b1;
  @(posedge clk);
  rerun_ready <= 1'b0;
endtask

task automatic retire_head();
  wait_done();
  check_eq(32'(done_index), 32'(model_head), "retire index");
  check_eq(32'(done_cmt_id), 32'(exp_ids.pop_front()), "retired commit id");
  @(posedge clk);
  done_ready <= 1'b1;
  @(posedge clk);
  done_ready <= 1'b0;
  model_head = model_head + ldq_idx_t'(1);
endtask

task automatic test_reset_capacity();
  ldq_idx_t idx;
  @(negedge clk);
  check_eq(32'(disp_ready), 1, "dispatch ready after reset");
  check_eq(32'(rerun_valid), 0, "rerun valid after reset");
  check_eq(32'(done_valid), 0, "done valid after reset");
  repeat (LDQ_SIZE) dispatch_load(idx);
  @(negedge clk);
  check_eq(32'(disp_ready), 0, "dispatch ready with queue full");
  for (int i = 0; i < LDQ_SIZE; i++) finish_load(ldq_idx_t'(i));
  repeat (LDQ_SIZE) retire_head();
  @(negedge clk);
  check_eq(32'(done_valid), 0, "done valid after capacity test");
endtask

task automatic test_clean_load();
  ldq_idx_t idx;
  dispatch_load(idx);
  finish_load(idx);
  @(negedge clk);
  check_eq(32'(done_valid), 1, "done one cycle after EX2");
  retire_head();
  @(negedge clk);
  check_eq(32'(done_valid), 0, "done valid after retire");
  // a full round of dispatches lands on the retired entry again
  repeat (LDQ_SIZE) dispatch_load(idx);
  @(negedge clk);
  check_eq(32'(disp_ready), 0, "dispatch ready with queue refilled");
  for (int i = 1; i <= LDQ_SIZE; i++) finish_load(idx + ldq_idx_t'(i));
  repeat (LDQ_SIZE) retire_head();
endtask

task automatic test_tlb_hazard();
  ldq_idx_t idx;
  vaddr_t   va;
  dispatch_load(idx);
  va = next_bits(VADDR_W);
  ex1_update(idx, 1'b1, va);
  repeat (3) begin
    @(negedge clk);
    check_eq(32'(rerun_valid), 0, "rerun before TLB resolve");
  end
  tlb_pulse();
  @(negedge clk);
  check_eq(32'(rerun_valid), 1, "rerun after TLB resolve");
  take_rerun(idx, va);
  finish_load(idx);
  retire_head();
endtask

task automatic lrq_release_case(input ex2_haz_e typ);
  ldq_idx_t idx;
  vaddr_t   va;
  dispatch_load(idx);
  va = next_bits(VADDR_W);
  ex1_update(idx, 1'b0, va);
  ex2_update(idx, typ, 8'h08, 1'b0);  // slot 3
  lrq_pulse(8'h20);                   // slot 5
  @(negedge clk);
  check_eq(32'(rerun_valid), 0, "rerun after other LRQ slot");
  lrq_pulse(8'h08);
  @(negedge clk);
  check_eq(32'(rerun_valid), 1, "rerun after matching LRQ slot");
  take_rerun(idx, va);
  finish_load(idx);
  retire_head();
endtask

task automatic ready_at_once_case(input ex2_haz_e typ, input logic same_rel);
  ldq_idx_t idx;
  vaddr_t   va;
  dispatch_load(idx);
  va = next_bits(VADDR_W);
  ex1_update(idx, 1'b0, va);
  ex2_update(idx, typ, 8'h08, same_rel);
  @(negedge clk);
  check_eq(32'(rerun_valid), 1, "rerun right after EX2");
  take_rerun(idx, va);
  finish_load(idx);
  retire_head();
endtask

task automatic test_lrq_hazards();
  lrq_release_case(LRQ_CONFLICT);
  lrq_release_case(LRQ_FULL);
  ready_at_once_case(LRQ_CONFLICT, 1'b1);
  ready_at_once_case(L1D_CONFLICT, 1'b0);
  ready_at_once_case(LRQ_ASSIGNED, 1'b0);
endtask

task automatic test_rerun_order();
  ldq_idx_t a, b, c;
  vaddr_t   va, vb, vc;
  dispatch_load(a);
  dispatch_load(b);
  dispatch_load(c);
  va = next_bits(VADDR_W);
  vb = next_bits(VADDR_W);
  vc = next_bits(VADDR_W);
  ex1_update(a, 1'b1, va);
  ex1_update(b, 1'b1, vb);
  ex1_update(c, 1'b0, vc);
  ex2_update(c, L1D_CONFLICT, '0, 1'b0);  // youngest is ready first
  wait_rerun();
  tlb_pulse();
  repeat (3) begin
    @(negedge clk);
    check_eq(32'(rerun_index), 32'(c), "held rerun index");
    check_eq(rerun_vaddr, vc, "held rerun vaddr");
  end
  take_rerun(c, vc);
  take_rerun(a, va);
  take_rerun(b, vb);
  finish_load(a);
  finish_load(b);
  finish_load(c);
  repeat (3) retire_head();
endtask

task automatic test_inorder_retire();
  ldq_idx_t a, b;
  dispatch_load(a);
  dispatch_load(b);
  finish_load(b);
  repeat (3) begin
    @(negedge clk);
    check_eq(32'(done_valid), 0, "done while older load pending");
  end
  finish_load(a);
  retire_head();
  retire_head();
  @(negedge clk);
  check_eq(32'(done_valid), 0, "done valid after retire test");
endtask

//--- tests/ldq_tb.sv
`timescale 1ns/1ns

module ldq_tb;

  import ldq_conf_pkg::*;
  import ldq_types_pkg::*;

  localparam int TIMEOUT = 50;  // cycles allowed per wait

  logic       clk;
  logic       reset_n;
  logic       disp_valid;
  cmt_id_t    disp_cmt_id;
  logic       disp_ready;
  ldq_idx_t   disp_index;
  logic       ex1_valid;
  ldq_idx_t   ex1_index;
  logic       ex1_tlb_haz;
  vaddr_t     ex1_vaddr;
  logic       ex2_valid;
  ldq_idx_t   ex2_index;
  ex2_haz_e   ex2_haz_typ;
  lrq_oh_t    ex2_lrq_oh;
  logic       tlb_resolve;
  logic       lrq_resolve_valid;
  lrq_oh_t    lrq_resolve_oh;
  logic       rerun_valid;
  ldq_idx_t   rerun_index;
  vaddr_t     rerun_vaddr;
  logic       rerun_ready;
  logic       done_valid;
  ldq_idx_t   done_index;
  cmt_id_t    done_cmt_id;
  logic       done_ready;

  cmt_id_t     exp_ids[$];  // commit ids in dispatch order
  ldq_idx_t    model_head;
  ldq_idx_t    model_tail;
  logic [15:0] lfsr_q = 16'd74;

  ldq_top ldq_top_i (
    .i_clk               (clk),
    .i_reset_n           (reset_n),
    .i_disp_valid        (disp_valid),
    .i_disp_cmt_id       (disp_cmt_id),
    .o_disp_ready        (disp_ready),
    .o_disp_index        (disp_index),
    .i_ex1_valid         (ex1_valid),
    .i_ex1_index         (ex1_index),
    .i_ex1_tlb_haz       (ex1_tlb_haz),
    .i_ex1_vaddr         (ex1_vaddr),
    .i_ex2_valid         (ex2_valid),
    .i_ex2_index         (ex2_index),
    .i_ex2_haz_typ       (ex2_haz_typ),
    .i_ex2_lrq_oh        (ex2_lrq_oh),
    .i_tlb_resolve       (tlb_resolve),
    .i_lrq_resolve_valid (lrq_resolve_valid),
    .i_lrq_resolve_oh    (lrq_resolve_oh),
    .o_rerun_valid       (rerun_valid),
    .o_rerun_index       (rerun_index),
    .o_rerun_vaddr       (rerun_vaddr),
    .i_rerun_ready       (rerun_ready),
    .o_done_valid        (done_valid),
    .o_done_index        (done_index),
    .o_done_cmt_id       (done_cmt_id),
    .i_done_ready        (done_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b      = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (b) lfsr_q = lfsr_q ^ 16'hB400;
      v = {v[30:0], b};
    end
    return v;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at %0t ns", $time);
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t ns: %s, got %0h, expected %0h",
                         $time, what, got, exp));
    end
  endtask

  task automatic wait_rerun();
    int n;
    n = 0;
    @(negedge clk);
    while (!rerun_valid) begin
      n++;
      if (n > TIMEOUT) stop_run("Timeout: no rerun request was offered");
      @(negedge clk);
    end
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    @(negedge clk);
    while (!done_valid) begin
      n++;
      if (n > TIMEOUT) stop_run("Timeout: the head load never became done");
      @(negedge clk);
    end
  endtask

  `include "ldq_tb_tasks.svh"

  initial begin
    reset_n           = 1'b0;
    disp_valid        = 1'b0;
    disp_cmt_id       = '0;
    ex1_valid         = 1'b0;
    ex1_index         = '0;
    ex1_tlb_haz       = 1'b0;
    ex1_vaddr         = '0;
    ex2_valid         = 1'b0;
    ex2_index         = '0;
    ex2_haz_typ       = NONE;
    ex2_lrq_oh        = '0;
    tlb_resolve       = 1'b0;
    lrq_resolve_valid = 1'b0;
    lrq_resolve_oh    = '0;
    rerun_ready       = 1'b0;
    done_ready        = 1'b0;
    model_head        = '0;
    model_tail        = '0;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;

    test_reset_capacity();
    test_clean_load();
    test_tlb_hazard();
    test_lrq_hazards();
    test_rerun_order();
    test_inorder_retire();

    $display("TB PASSED");
    $finish;
  end

endmodule

//--- ldq.f
+incdir+tests
hdl/ldq_conf_pkg.sv
hdl/ldq_types_pkg.sv
hdl/ldq_entry.sv
hdl/ldq_rerun_pick.sv
hdl/ldq_retire_ctl.sv
hdl/ldq_top.sv
tests/ldq_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the LDQ testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module ldq_tb -f ldq.f -o ldq_sim \
  || { echo "build failed"; exit 1; }

./obj_dir/ldq_sim > sim.log 2>&1
cat sim.log

grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"
